// ==== include/router_consts.svh ====
`ifndef ROUTER_CONSTS_SVH
`define ROUTER_CONSTS_SVH

// Local, North, East, West and South inputs share the one output channel
`define ROUTER_PORTS 5

`define FLIT_DATA_W 32
`define FLIT_ID_W 3

// A header carries its slice length in the low bits of its data
`define FLIT_LEN_W 12

`define FLIT_ID_HEAD 3'd1
`define FLIT_ID_BODY 3'd2
`define FLIT_ID_TAIL 3'd3

`endif

// ==== logic/routerPkg.sv ====
`include "router_consts.svh"

package routerPkg;

  typedef struct packed {
    logic [`FLIT_ID_W-1:0] id;
    logic [`FLIT_DATA_W-1:0] data;
  } Flit;

  // What a decoder tells the arbiter and the output stage about its buffer
  typedef struct packed {
    logic valid;
    logic isHead;
    logic [`FLIT_LEN_W-1:0] length;
    Flit flit;
  } PortReq;

  // Bit 0 is Local and bit 4 is South while all zero means no grant
  typedef logic [`ROUTER_PORTS-1:0] PortMask;

  typedef enum logic [2:0] {
    LocalPort,
    NorthPort,
    EastPort,
    WestPort,
    SouthPort
  } PortIdx;

endpackage

// ==== logic/flitDecoder.sv ====
`timescale 1ns/1ns
`include "router_consts.svh"

module flitDecoder
(
  input  logic clk,
  input  logic rst,
  input  routerPkg::Flit inFlit,
  input  logic inValid,
  output logic inReady,
  input  logic pop,
  output routerPkg::PortReq req
);

  import routerPkg::*;

  Flit held;
  logic full;
  logic accept;

  // A popped entry frees the slot in the same cycle, so a steady stream never bubbles
  assign inReady = !full || pop;
  assign accept = inValid && inReady;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      full <= 1'b0;
    end
    else if (accept)
    begin
      full <= 1'b1;
    end
    else if (pop)
    begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      held <= inFlit;
    end
  end

  always_comb
  begin
    req.valid = full;
    req.isHead = (held.id == `FLIT_ID_HEAD);
    // Only a header has a meaningful length field
    if (req.isHead)
    begin
      req.length = held.data[`FLIT_LEN_W-1:0];
    end
    else
    begin
      req.length = '0;
    end
    req.flit = held;
  end

endmodule

// ==== logic/portTimer.sv ====
`timescale 1ns/1ns
`include "router_consts.svh"

module portTimer
(
  input  logic clk,
  input  logic rst,
  input  logic load,
  input  logic [`FLIT_LEN_W-1:0] length,
  input  logic run,
  input  logic count,
  output logic timesUp
);

  logic [`FLIT_LEN_W-1:0] budget;
  logic [`FLIT_LEN_W-1:0] sent;
  logic [`FLIT_LEN_W-1:0] budgetNext;
  logic [`FLIT_LEN_W-1:0] sentNext;

  always_comb
  begin
    budgetNext = load ? length : budget;
    if (!run)
    begin
      sentNext = '0;
    end
    else if (load)
    begin
      // The header itself is the first flit of the slice
      sentNext = `FLIT_LEN_W'(1);
    end
    else if (count)
    begin
      sentNext = sent + 1'b1;
    end
    else
    begin
      sentNext = sent;
    end
  end

  // Includes the transfer in flight so the grant moves on the edge that spends the slice
  assign timesUp = (sentNext != '0) && (sentNext >= budgetNext);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      sent <= '0;
    end
    else
    begin
      budget <= budgetNext;
      sent <= sentNext;
    end
  end

endmodule

// ==== logic/outputArbiter.sv ====
`timescale 1ns/1ns
`include "router_consts.svh"

module outputArbiter
(
  input  logic clk,
  input  logic rst,
  input  routerPkg::PortReq req [`ROUTER_PORTS],
  input  logic xfer,
  output routerPkg::PortMask grant
);

  import routerPkg::*;

  PortMask state;
  PortMask nextState;
  logic [`ROUTER_PORTS-1:0] requesting;
  logic [`ROUTER_PORTS-1:0] timesUp;

  // Fixed order from Idle with Local first
  function automatic PortMask firstPick(input logic [`ROUTER_PORTS-1:0] reqs);
    PortMask pick;
    pick = '0;
    for (int idx = 0; idx < `ROUTER_PORTS; idx++)
    begin
      if (pick == '0 && reqs[idx])
      begin
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  // Search starts just after the previous owner and never comes back to it
  function automatic PortMask rotatePick(
    input logic [`ROUTER_PORTS-1:0] reqs,
    input PortIdx owner
  );
    PortMask pick;
    int idx;
    pick = '0;
    for (int step = 1; step < `ROUTER_PORTS; step++)
    begin
      idx = (int'(owner) + step) % `ROUTER_PORTS;
      if (pick == '0 && reqs[idx])
      begin
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  function automatic PortMask holdOrPass(
    input logic [`ROUTER_PORTS-1:0] reqs,
    input logic [`ROUTER_PORTS-1:0] spent,
    input PortIdx owner
  );
    PortMask keep;
    keep = '0;
    keep[owner] = 1'b1;
    if (reqs[owner] && !spent[owner])
    begin
      return keep;
    end
    return rotatePick(reqs, owner);
  endfunction

  for (genvar i = 0; i < `ROUTER_PORTS; i++)
  begin : slices
    assign requesting[i] = req[i].valid;

    portTimer sliceTimer
    (
      .clk(clk),
      .rst(rst),
      .load(xfer && state[i] && req[i].isHead),
      .length(req[i].length),
      .run(state[i]),
      .count(xfer && state[i]),
      .timesUp(timesUp[i])
    );
  end

  always_comb
  begin
    case (state)
      5'b00000: nextState = firstPick(requesting);
      5'b00001: nextState = holdOrPass(requesting, timesUp, LocalPort);
      5'b00010: nextState = holdOrPass(requesting, timesUp, NorthPort);
      5'b00100: nextState = holdOrPass(requesting, timesUp, EastPort);
      5'b01000: nextState = holdOrPass(requesting, timesUp, WestPort);
      5'b10000: nextState = holdOrPass(requesting, timesUp, SouthPort);
      default: nextState = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= '0;
    end
    else
    begin
      state <= nextState;
    end
  end

  assign grant = state;

endmodule

// ==== logic/outputStage.sv ====
`timescale 1ns/1ns
`include "router_consts.svh"

module outputStage
(
  input  logic clk,
  input  logic rst,
  input  routerPkg::PortReq req [`ROUTER_PORTS],
  input  routerPkg::PortMask grant,
  output logic xfer,
  output routerPkg::Flit outFlit,
  output logic outValid,
  input  logic outReady
);

  import routerPkg::*;

  PortReq picked;

  // The grant is one-hot or zero, so an OR of the gated requests is the mux
  always_comb
  begin
    picked = '0;
    for (int i = 0; i < `ROUTER_PORTS; i++)
    begin
      if (grant[i])
      begin
        picked = PortReq'(picked | req[i]);
      end
    end
  end

  assign xfer = picked.valid && (!outValid || outReady);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else if (xfer)
    begin
      outValid <= 1'b1;
    end
    else if (outReady)
    begin
      outValid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (xfer)
    begin
      outFlit <= picked.flit;
    end
  end

endmodule

// ==== logic/routerOutputPort.sv ====
`timescale 1ns/1ns
`include "router_consts.svh"

module routerOutputPort
(
  input  logic clk,
  input  logic rst,
  input  routerPkg::Flit inFlit [`ROUTER_PORTS],
  input  logic [`ROUTER_PORTS-1:0] inValid,
  output logic [`ROUTER_PORTS-1:0] inReady,
  output routerPkg::Flit outFlit,
  output logic outValid,
  input  logic outReady
);

  import routerPkg::*;

  PortReq req [`ROUTER_PORTS];
  PortMask grant;
  logic xfer;

  // Each port's input buffer pops when its flit moves to the output
  for (genvar i = 0; i < `ROUTER_PORTS; i++)
  begin : decoders
    flitDecoder decoder
    (
      .clk(clk),
      .rst(rst),
      .inFlit(inFlit[i]),
      .inValid(inValid[i]),
      .inReady(inReady[i]),
      .pop(grant[i] && xfer),
      .req(req[i])
    );
  end

  outputArbiter arbiter
  (
    .clk(clk),
    .rst(rst),
    .req(req),
    .xfer(xfer),
    .grant(grant)
  );

  outputStage result
  (
    .clk(clk),
    .rst(rst),
    .req(req),
    .grant(grant),
    .xfer(xfer),
    .outFlit(outFlit),
    .outValid(outValid),
    .outReady(outReady)
  );

endmodule

// ==== tests/routerOutput_asserts.sv ====
`timescale 1ns/1ns

module routerOutput_asserts
(
  input logic clk,
  input logic rst,
  input routerPkg::PortMask grant,
  input logic xfer,
  input routerPkg::Flit outFlit,
  input logic outValid,
  input logic outReady
);

  int violations = 0;

  // Only one input may own the channel at a time
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
  else
  begin
    violations++;
    $error("grant is not one-hot or zero: %b", grant);
  end

  // A stalled output flit must wait unchanged for the consumer
  outputHeld: assert property (@(posedge clk) disable iff (rst)
    (outValid && !outReady) |=> (outValid && $stable(outFlit)))
  else
  begin
    violations++;
    $error("output flit changed or dropped while stalled");
  end

  xferGranted: assert property (@(posedge clk) disable iff (rst) xfer |-> (grant != '0))
  else
  begin
    violations++;
    $error("flit moved to the output with no port granted");
  end

endmodule

// ==== tests/routerTb.sv ====
`timescale 1ns/1ns
`include "router_consts.svh"

module routerTb;

  import routerPkg::*;

  localparam int maxFlits = 8;
  localparam int cycleLimit = 200;

  logic clk = 1'b0;
  logic rst;
  Flit inFlit [`ROUTER_PORTS];
  logic [`ROUTER_PORTS-1:0] inValid;
  logic [`ROUTER_PORTS-1:0] inReady;
  Flit outFlit;
  logic outValid;
  logic outReady;

  // Per-port stimulus and the flits seen leaving the DUT
  Flit stim [`ROUTER_PORTS][maxFlits];
  int stimCount [`ROUTER_PORTS];
  Flit got [$];
  Flit expected [$];
  logic [31:0] lfsrState = 32'h4f317287;
  int testsRun = 0;
  int testsFailed = 0;

  routerOutputPort u_routerOutputPort
  (
    .clk(clk),
    .rst(rst),
    .inFlit(inFlit),
    .inValid(inValid),
    .inReady(inReady),
    .outFlit(outFlit),
    .outValid(outValid),
    .outReady(outReady)
  );

  bind routerOutputPort routerOutput_asserts protocolChecks
  (
    .clk(clk),
    .rst(rst),
    .grant(grant),
    .xfer(xfer),
    .outFlit(outFlit),
    .outValid(outValid),
    .outReady(outReady)
  );

  always #2 clk = !clk;

  function automatic logic [31:0] lfsrStep(input logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ 32'h80200003;
    return state >> 1;
  endfunction

  task automatic clearStimulus();
    foreach (stimCount[p])
      stimCount[p] = 0;
  endtask

  // Data holds port, sequence number and test tag, and a header's slice length in the low bits
  task automatic makePacket(input PortIdx port, input int flits, input int sliceLen, input int tag);
    Flit f;
    for (int s = 0; s < flits; s++)
    begin
      if (s == 0)
        f.id = `FLIT_ID_HEAD;
      else if (s == flits - 1)
        f.id = `FLIT_ID_TAIL;
      else
        f.id = `FLIT_ID_BODY;
      f.data = {4'(port), 8'(s), 8'(tag), (s == 0) ? 12'(sliceLen) : 12'h0};
      stim[port][stimCount[port]] = f;
      stimCount[port]++;
    end
  endtask

  // Arbiter model per slice that rotates past the last owner or falls back to the Idle order
  function automatic void buildExpected();
    int sentIdx [`ROUTER_PORTS];
    int budget [`ROUTER_PORTS];
    int owner;
    int pick;
    int idx;
    int used;
    logic more;
    Flit f;
    expected.delete();
    foreach (sentIdx[p])
    begin
      sentIdx[p] = 0;
      budget[p] = 0;
    end
    owner = -1;
    pick = 0;
    while (pick >= 0)
    begin
      pick = -1;
      for (int step = 1; step < `ROUTER_PORTS && owner >= 0; step++)
      begin
        idx = (owner + step) % `ROUTER_PORTS;
        if (pick < 0 && sentIdx[idx] < stimCount[idx])
          pick = idx;
      end
      for (int p = 0; p < `ROUTER_PORTS; p++)
        if (pick < 0 && sentIdx[p] < stimCount[p])
          pick = p;
      if (pick >= 0)
      begin
        used = 0;
        more = 1'b1;
        while (more)
        begin
          f = stim[pick][sentIdx[pick]];
          sentIdx[pick]++;
          expected.push_back(f);
          used = (f.id == `FLIT_ID_HEAD) ? 1 : used + 1;
          if (f.id == `FLIT_ID_HEAD)
            budget[pick] = int'(f.data[`FLIT_LEN_W-1:0]);
          more = (used < budget[pick]) && (sentIdx[pick] < stimCount[pick]);
        end
        owner = pick;
      end
    end
  endfunction

  // Inputs change on the falling edge and handshakes are sampled 1 ns before the rising edge
  task automatic streamTraffic(input string name, input int stopAt, input logic randomStall,
                               output logic timedOut);
    int sentIdx [`ROUTER_PORTS];
    int cycles;
    got.delete();
    timedOut = 1'b0;
    cycles = 0;
    foreach (sentIdx[p])
      sentIdx[p] = 0;
    while (got.size() < stopAt && !timedOut)
    begin
      @(negedge clk);
      for (int p = 0; p < `ROUTER_PORTS; p++)
      begin
        inValid[p] = (sentIdx[p] < stimCount[p]);
        if (inValid[p])
          inFlit[p] = stim[p][sentIdx[p]];
      end
      if (randomStall)
      begin
        lfsrState = lfsrStep(lfsrState);
        outReady = lfsrState[0];
      end
      else
        outReady = 1'b1;
      #1;
      for (int p = 0; p < `ROUTER_PORTS; p++)
        if (inValid[p] && inReady[p])
          sentIdx[p]++;
      if (outValid && outReady)
        got.push_back(outFlit);
      cycles++;
      if (cycles >= cycleLimit)
      begin
        $display("%s: timed out waiting for output flits, %0d of %0d arrived",
                 name, got.size(), stopAt);
        timedOut = 1'b1;
      end
    end
  endtask

  function automatic int compareOutput(input string name);
    int errs;
    errs = 0;
    if (got.size() != expected.size())
    begin
      $display("error %s: flit count expected %0d actual %0d", name, expected.size(), got.size());
      errs++;
    end
    for (int i = 0; i < got.size() && i < expected.size(); i++)
      if (got[i] !== expected[i])
      begin
        $display("error %s: flit %0d expected %h actual %h", name, i, expected[i], got[i]);
        errs++;
      end
    return errs;
  endfunction

  task automatic runPackets(input string name, input logic randomStall, output int errs);
    logic timedOut;
    buildExpected();
    streamTraffic(name, expected.size(), randomStall, timedOut);
    // A few quiet cycles expose any duplicated flit
    for (int c = 0; c < 4; c++)
    begin
      @(negedge clk);
      inValid = '0;
      outReady = 1'b1;
      #1;
      if (outValid)
        got.push_back(outFlit);
    end
    errs = compareOutput(name) + (timedOut ? 1 : 0);
  endtask

  task automatic reportTest(input string name, input int errs);
    testsRun++;
    if (errs == 0)
      $display("%s: ok", name);
    else
    begin
      testsFailed++;
      $display("%s: failed with %0d errors", name, errs);
    end
  endtask

  task automatic applyReset();
    rst = 1'b1;
    inValid = '0;
    outReady = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic singlePacketTest();
    int errs;
    clearStimulus();
    makePacket(LocalPort, 4, 4, 1);
    runPackets("single packet", 1'b0, errs);
    reportTest("single packet", errs);
  endtask

  task automatic allPortsTest(input string name, input logic randomStall);
    int errs;
    clearStimulus();
    for (int p = 0; p < `ROUTER_PORTS; p++)
      makePacket(PortIdx'(p), 3, 3, 2);
    runPackets(name, randomStall, errs);
    reportTest(name, errs);
  endtask

  task automatic sliceExpiryTest();
    int errs;
    clearStimulus();
    makePacket(LocalPort, 4, 2, 3);
    makePacket(NorthPort, 2, 2, 3);
    runPackets("slice expiry", 1'b0, errs);
    reportTest("slice expiry", errs);
  endtask

  task automatic resetTest();
    int errs;
    int packetErrs;
    logic timedOut;
    errs = 0;
    clearStimulus();
    for (int p = 0; p < `ROUTER_PORTS; p++)
      makePacket(PortIdx'(p), 3, 3, 5);
    streamTraffic("reset", 4, 1'b0, timedOut);
    if (timedOut)
      errs++;
    @(negedge clk);
    applyReset();
    #1;
    if (outValid !== 1'b0)
    begin
      $display("error reset: outValid expected 0 actual %b", outValid);
      errs++;
    end
    if (inReady !== '1)
    begin
      $display("error reset: inReady expected %b actual %b", 5'b11111, inReady);
      errs++;
    end
    clearStimulus();
    makePacket(LocalPort, 4, 4, 6);
    runPackets("reset", 1'b0, packetErrs);
    reportTest("reset", errs + packetErrs);
  endtask

  initial
  begin
    rst = 1'b1;
    inValid = '0;
    outReady = 1'b1;
    foreach (inFlit[p])
      inFlit[p] = '0;
    applyReset();
    singlePacketTest();
    allPortsTest("all ports", 1'b0);
    sliceExpiryTest();
    allPortsTest("back-pressure", 1'b1);
    resetTest();
    if (u_routerOutputPort.protocolChecks.violations != 0)
    begin
      $display("protocol assertions failed %0d times",
               u_routerOutputPort.protocolChecks.violations);
    end
    $display("%0d tests run, %0d passed, %0d failed", testsRun, testsRun - testsFailed,
             testsFailed);
    if (testsFailed == 0 && u_routerOutputPort.protocolChecks.violations == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
logic/routerPkg.sv
logic/flitDecoder.sv
logic/portTimer.sv
logic/outputArbiter.sv
logic/outputStage.sv
logic/routerOutputPort.sv
tests/routerOutput_asserts.sv
tests/routerTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= routerTb
FILELIST ?= sources.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= Test failures found
VFLAGS ?= --binary --timing --assert -j 0
SIMFLAGS ?= +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, and a crashed or stopped run also fails
sim: build
	./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failures"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "Simulator exited with status $$status"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
